/* tb.f */
+incdir+rtl
rtl/rv64_pkg.sv
rtl/int_alu.sv
rtl/next_pc_unit.sv
rtl/retire_unit.sv
rtl/rv64_core.sv
test/clk_gen.sv
test/tb_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_core -f tb.f -o sim_tb_core > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_tb_core > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "PASS: all tests" "$SIM_LOG"; then
	exit 0
fi
exit 1

/* test/tb_core.sv */
`default_nettype none
`timescale 1ns/1ps

`include "rv64_config.svh"

module tb_core;
	import rv64_pkg::*;

	localparam int N_INST     = 400;
	localparam int RETIRE_TMO = 8;
	localparam int RESET_TMO  = 10;

	logic		CLK;
	logic		RSTn;
	inst_u		inst;
	logic		inst_valid;
	xlen_t		pc;
	retire_t	retire;

	xlen_t		regs [`NUM_REG];	// Reference register file
	xlen_t		mpc;
	logic [31:0]	rng;
	int		n_mismatch;
	int		n_timeout;
	int		n_other;

	clk_gen clk_gen_i (
		.CLK	(CLK),
		.RSTn	(RSTn)
	);

	rv64_core dut_i (
		.CLK		(CLK),
		.RSTn		(RSTn),
		.inst_i		(inst),
		.inst_valid_i	(inst_valid),
		.pc_o		(pc),
		.retire_o	(retire)
	);

	function automatic logic [31:0] xorshift32();
		rng ^= rng << 13;
		rng ^= rng >> 17;
		rng ^= rng << 5;
		return rng;
	endfunction

	// ISA reference for one instruction, state is committed by the caller
	task automatic model_step(input logic [31:0] w, output retire_t exp, output xlen_t npc);
		logic [2:0]	f3;
		logic		alt;
		logic		tk;
		logic [5:0]	sh;
		logic [31:0]	r32;
		xlen_t		a;
		xlen_t		b;
		xlen_t		imm;
		f3  = w[14:12];
		alt = w[30];
		a   = regs[w[19:15]];
		b   = regs[w[24:20]];
		imm = {{52{w[31]}}, w[31:20]};
		npc = mpc + 64'd4;
		exp = '0;
		exp.valid = 1'b1;
		exp.wb.rd = w[11:7];
		exp.wb.we = w[11:7] != 5'd0;
		case (w[6:0])
		7'b0110011, 7'b0010011: begin	// OP, OP-IMM
			if (w[5] == 1'b0) begin
				b   = imm;
				alt = alt && f3 == 3'b101;
			end
			sh = b[5:0];
			case (f3)
			3'b000: exp.wb.data = alt ? a - b : a + b;
			3'b001: exp.wb.data = a << sh;
			3'b010: exp.wb.data = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
			3'b011: exp.wb.data = (a < b) ? 64'd1 : 64'd0;
			3'b100: exp.wb.data = a ^ b;
			3'b101: begin
				if (alt)
					exp.wb.data = $signed(a) >>> sh;
				else
					exp.wb.data = a >> sh;
			end
			3'b110: exp.wb.data = a | b;
			default: exp.wb.data = a & b;
			endcase
		end
		7'b0111011, 7'b0011011: begin	// OP-32, OP-IMM-32
			if (w[5] == 1'b0) begin
				b   = imm;
				alt = alt && f3 == 3'b101;
			end
			case (f3)
			3'b000: r32 = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
			3'b001: r32 = a[31:0] << b[4:0];
			default: begin
				if (alt)
					r32 = $signed(a[31:0]) >>> b[4:0];
				else
					r32 = a[31:0] >> b[4:0];
			end
			endcase
			exp.wb.data = {{32{r32[31]}}, r32};
		end
		7'b0110111: exp.wb.data = {{32{w[31]}}, w[31:12], 12'h000};		// LUI
		7'b0010111: exp.wb.data = mpc + {{32{w[31]}}, w[31:12], 12'h000};	// AUIPC
		7'b1101111: begin	// JAL
			exp.wb.data = mpc + 64'd4;
			npc = mpc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		end
		7'b1100111: begin	// JALR, bit 0 not cleared
			exp.wb.data = mpc + 64'd4;
			npc = a + imm;
		end
		7'b1100011: begin	// Branches
			exp.wb.we = 1'b0;
			case (f3)
			3'b000: tk = a == b;
			3'b001: tk = a != b;
			3'b100: tk = $signed(a) < $signed(b);
			3'b101: tk = $signed(a) >= $signed(b);
			3'b110: tk = a < b;
			default: tk = a >= b;
			endcase
			if (tk)
				npc = mpc + {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		end
		default: exp.wb.we = 1'b0;	// Unsupported opcode
		endcase
	endtask

	// Random fields with opcode and funct bits forced to a legal pattern
	task automatic gen_inst(output logic [31:0] w, output string name);
		logic [31:0]	r;
		logic [2:0]	f3;
		r  = xorshift32();
		w  = xorshift32();
		f3 = r[9] ? 3'b101 : (r[8] ? 3'b001 : 3'b000);	// Word op funct3
		case (r[3:0])
		4'd0, 4'd1: begin
			name = "op";
			w[6:0] = 7'b0110011;
			w[31:25] = (r[10] && (w[14:12] == 3'b000 || w[14:12] == 3'b101)) ?
				7'h20 : 7'h00;
		end
		4'd2, 4'd3: begin
			name = "op_imm";
			w[6:0] = 7'b0010011;
			if (w[14:12] == 3'b001)
				w[31:26] = 6'b000000;
			else if (w[14:12] == 3'b101)
				w[31:26] = r[10] ? 6'b010000 : 6'b000000;
		end
		4'd4, 4'd5: begin
			name = "op_32";
			w[6:0] = 7'b0111011;
			w[14:12] = f3;
			w[31:25] = (r[10] && f3 != 3'b001) ? 7'h20 : 7'h00;
		end
		4'd6, 4'd7: begin
			name = "op_imm_32";
			w[6:0] = 7'b0011011;
			w[14:12] = f3;
			if (f3 != 3'b000)
				w[31:25] = (r[10] && f3 == 3'b101) ? 7'h20 : 7'h00;
		end
		4'd8: begin
			name = "lui";
			w[6:0] = 7'b0110111;
		end
		4'd9: begin
			name = "auipc";
			w[6:0] = 7'b0010111;
		end
		4'd10: begin
			name = "jal";
			w[6:0] = 7'b1101111;
		end
		4'd11: begin
			name = "jalr";
			w[6:0] = 7'b1100111;
			w[14:12] = 3'b000;
		end
		4'd15: begin
			name = "unsupported";
			w[6:0] = r[11] ? (r[12] ? 7'b0000011 : 7'b0100011) :
				(r[12] ? 7'b1110011 : 7'b0001111);
		end
		default: begin
			name = "branch";
			w[6:0] = 7'b1100011;
			if (w[14:13] == 2'b01)
				w[14] = 1'b1;	// funct3 2 and 3 are not branches
		end
		endcase
	endtask

	task automatic check_retire(input string name, input retire_t exp, input retire_t act);
		if (act.valid !== exp.valid || act.wb.we !== exp.wb.we ||
				(exp.wb.we && (act.wb.rd !== exp.wb.rd ||
				act.wb.data !== exp.wb.data))) begin
			$display("mismatch %s retire: expected %h, actual %h", name, exp, act);
			n_mismatch++;
		end
	endtask

	task automatic check_pc(input string name, input xlen_t exp, input xlen_t act);
		if (act !== exp) begin
			$display("mismatch %s pc: expected %h, actual %h", name, exp, act);
			n_mismatch++;
		end
	endtask

	task automatic wait_retire(output bit ok, output int late);
		int n;
		n = 0;
		@(negedge CLK);
		while (retire.valid !== 1'b1 && n < RETIRE_TMO) begin
			inst_valid = 1'b0;
			n++;
			@(negedge CLK);
		end
		ok   = retire.valid === 1'b1;
		late = n;
	endtask

	// Drive on the falling edge, check on the next one
	task automatic run_inst(input logic [31:0] w, input string name);
		retire_t	exp;
		xlen_t		npc;
		bit		ok;
		int		late;
		inst       = w;
		inst_valid = 1'b1;
		model_step(w, exp, npc);
		wait_retire(ok, late);
		if (!ok) begin
			$display("no retire pulse for %s instruction %h within %0d cycles", name, w,
				RETIRE_TMO);
			n_timeout++;
		end else begin
			if (late != 0) begin
				$display("retire for %s instruction %h came %0d cycles late", name, w,
					late);
				n_other++;
			end
			check_retire(name, exp, retire);
			check_pc(name, npc, pc);
		end
		if (exp.wb.we)
			regs[exp.wb.rd] = exp.wb.data;
		mpc = npc;
	endtask

	task automatic idle_cycle();
		inst       = xorshift32();	// Junk word with valid low
		inst_valid = 1'b0;
		@(negedge CLK);
		if (retire.valid !== 1'b0) begin
			$display("retire pulse seen after a cycle without a valid instruction");
			n_other++;
		end
		check_pc("idle", mpc, pc);
	endtask

	// LUI then ADDI on the same register for wide operands
	task automatic seed_pair();
		logic [31:0]	r;
		logic [4:0]	rd;
		r  = xorshift32();
		rd = r[11:7];
		run_inst({r[31:12], rd, 7'b0110111}, "seed_lui");
		r = xorshift32();
		run_inst({r[31:20], rd, 3'b000, rd, 7'b0010011}, "seed_addi");
	endtask

	initial begin
		int		n;
		logic [31:0]	w;
		string		name;
		rng        = 32'd248;
		inst       = '0;
		inst_valid = 1'b0;
		n_mismatch = 0;
		n_timeout  = 0;
		n_other    = 0;
		mpc        = `RESET_PC;
		for (int i = 0; i < `NUM_REG; i++)
			regs[i] = '0;
		n = 0;
		while (RSTn !== 1'b1 && n < RESET_TMO) begin
			@(posedge CLK);
			n++;
		end
		if (RSTn !== 1'b1) begin
			$display("reset was never released");
			n_other++;
		end else begin
			@(negedge CLK);
			check_pc("reset", `RESET_PC, pc);
			if (retire.valid !== 1'b0) begin
				$display("retire valid is high right after reset");
				n_other++;
			end
			idle_cycle();
			for (int i = 0; i < N_INST; i++) begin
				if (i % 8 == 0)
					seed_pair();
				gen_inst(w, name);
				run_inst(w, name);
				if ((xorshift32() & 32'd7) == 32'd0)
					idle_cycle();
			end
		end
		$display("errors: %0d mismatches, %0d timeouts, %0d other", n_mismatch, n_timeout,
			n_other);
		if (n_mismatch + n_timeout + n_other == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

/* test/clk_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module clk_gen (
	output logic	CLK,
	output logic	RSTn
);
	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;	// 40 ns period
	end

	initial begin
		RSTn = 1'b0;
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		RSTn = 1'b1;	// Released away from the active edge
	end

endmodule

`default_nettype wire

/* rtl/rv64_core.sv */
`default_nettype none
`timescale 1ns/1ps

module rv64_core (
	input  wire			CLK,
	input  wire			RSTn,
	input  rv64_pkg::inst_u		inst_i,
	input  wire			inst_valid_i,
	output rv64_pkg::xlen_t		pc_o,
	output rv64_pkg::retire_t	retire_o
);
	import rv64_pkg::*;

	xlen_t		rs1_data;
	xlen_t		rs2_data;
	xlen_t		pc;
	xlen_t		pc_next;
	wb_t		wb;

	assign pc_o = pc;

	retire_unit retire_unit_i (
		.CLK		(CLK),
		.RSTn		(RSTn),
		.inst_valid_i	(inst_valid_i),
		.rs1_idx_i	(inst_i.r.rs1),
		.rs2_idx_i	(inst_i.r.rs2),
		.rs1_data_o	(rs1_data),
		.rs2_data_o	(rs2_data),
		.pc_o		(pc),
		.wb_i		(wb),
		.pc_next_i	(pc_next),
		.retire_o	(retire_o)
	);

	// Result and next PC are computed side by side
	int_alu int_alu_i (
		.inst_i		(inst_i),
		.rs1_data_i	(rs1_data),
		.rs2_data_i	(rs2_data),
		.pc_i		(pc),
		.wb_o		(wb)
	);

	next_pc_unit next_pc_unit_i (
		.inst_i		(inst_i),
		.rs1_data_i	(rs1_data),
		.rs2_data_i	(rs2_data),
		.pc_i		(pc),
		.pc_next_o	(pc_next)
	);

endmodule

`default_nettype wire

/* rtl/retire_unit.sv */
`default_nettype none
`timescale 1ns/1ps

`include "rv64_config.svh"

module retire_unit (
	input  wire			CLK,
	input  wire			RSTn,
	input  wire			inst_valid_i,
	input  rv64_pkg::reg_idx_t	rs1_idx_i,
	input  rv64_pkg::reg_idx_t	rs2_idx_i,
	output rv64_pkg::xlen_t		rs1_data_o,
	output rv64_pkg::xlen_t		rs2_data_o,
	output rv64_pkg::xlen_t		pc_o,
	input  rv64_pkg::wb_t		wb_i,
	input  rv64_pkg::xlen_t		pc_next_i,
	output rv64_pkg::retire_t	retire_o
);
	import rv64_pkg::*;

	xlen_t		reg_file [`NUM_REG];

	// x0 is hardwired
	assign rs1_data_o = (rs1_idx_i == '0) ? '0 : reg_file[rs1_idx_i];
	assign rs2_data_o = (rs2_idx_i == '0) ? '0 : reg_file[rs2_idx_i];

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			for (int i = 0; i < `NUM_REG; i++)
				reg_file[i] <= '0;
		end else if (inst_valid_i && wb_i.we) begin
			reg_file[wb_i.rd] <= wb_i.data;
		end
	end

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			pc_o <= `RESET_PC;
		end else if (inst_valid_i) begin
			pc_o <= pc_next_i;
		end
	end

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			retire_o <= '0;
		end else begin
			retire_o.valid <= inst_valid_i;	// One pulse per accepted inst
			retire_o.wb    <= wb_i;
		end
	end

	// No retire without an accepted instruction the cycle before
	a_retire_follows_valid: assert property (@(posedge CLK) disable iff (!RSTn)
		!inst_valid_i |=> !retire_o.valid)
		else $error("retire pulse without a valid instruction");

	a_x0_reads_zero: assert property (@(posedge CLK) disable iff (!RSTn)
		rs1_idx_i == '0 |-> rs1_data_o == '0)
		else $error("x0 read returned non-zero");

endmodule

`default_nettype wire

/* rtl/next_pc_unit.sv */
`default_nettype none
`timescale 1ns/1ps

module next_pc_unit (
	input  rv64_pkg::inst_u		inst_i,
	input  rv64_pkg::xlen_t		rs1_data_i,
	input  rv64_pkg::xlen_t		rs2_data_i,
	input  rv64_pkg::xlen_t		pc_i,
	output rv64_pkg::xlen_t		pc_next_o
);
	import rv64_pkg::*;

	xlen_t		imm_i;
	xlen_t		imm_b;
	xlen_t		imm_j;
	xlen_t		pc_plus4;
	logic		taken;

	assign imm_i = {{52{inst_i.i.imm[11]}}, inst_i.i.imm};

	// B and J immediates are scattered over the register view fields
	assign imm_b = {{51{inst_i.r.funct7[6]}}, inst_i.r.funct7[6], inst_i.r.rd[0],
			inst_i.r.funct7[5:0], inst_i.r.rd[4:1], 1'b0};
	assign imm_j = {{43{inst_i.r.funct7[6]}}, inst_i.r.funct7[6], inst_i.r.rs1,
			inst_i.r.funct3, inst_i.r.rs2[0], inst_i.r.funct7[5:0],
			inst_i.r.rs2[4:1], 1'b0};

	assign pc_plus4 = pc_i + 64'd4;

	always_comb begin
		case (inst_i.r.funct3)
		3'b000:	taken = rs1_data_i == rs2_data_i;			// BEQ
		3'b001:	taken = rs1_data_i != rs2_data_i;			// BNE
		3'b100:	taken = $signed(rs1_data_i) <  $signed(rs2_data_i);	// BLT
		3'b101:	taken = $signed(rs1_data_i) >= $signed(rs2_data_i);	// BGE
		3'b110:	taken = rs1_data_i <  rs2_data_i;			// BLTU
		3'b111:	taken = rs1_data_i >= rs2_data_i;			// BGEU
		default: taken = 1'b0;
		endcase
	end

	always_comb begin
		case (inst_i.r.opcode)
		JAL:	pc_next_o = pc_i + imm_j;
		JALR: begin
			// Bit 0 of the target is kept as is
			if (inst_i.i.funct3 == 3'b000)
				pc_next_o = rs1_data_i + imm_i;
			else
				pc_next_o = pc_plus4;
		end
		BRANCH:	pc_next_o = taken ? pc_i + imm_b : pc_plus4;
		default: pc_next_o = pc_plus4;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/int_alu.sv */
`default_nettype none
`timescale 1ns/1ps

module int_alu (
	input  rv64_pkg::inst_u		inst_i,
	input  rv64_pkg::xlen_t		rs1_data_i,
	input  rv64_pkg::xlen_t		rs2_data_i,
	input  rv64_pkg::xlen_t		pc_i,
	output rv64_pkg::wb_t		wb_o
);
	import rv64_pkg::*;

	xlen_t		imm_i;
	xlen_t		imm_u;
	logic [2:0]	f3;
	logic		f7_zero;
	logic		f7_alt;
	logic		f6_alt;		// SRAI marker in imm[11:6]
	logic		kept;
	xlen_t		res;

	function automatic xlen_t alu64(logic [2:0] op, logic alt, xlen_t a, xlen_t b,
			logic [5:0] sh);
		case (op)
		3'b000:	return alt ? a - b : a + b;
		3'b001:	return a << sh;
		3'b010:	return {63'd0, $signed(a) < $signed(b)};
		3'b011:	return {63'd0, a < b};
		3'b100:	return a ^ b;
		3'b101:	return alt ? xlen_t'($signed(a) >>> sh) : a >> sh;
		3'b110:	return a | b;
		default: return a & b;
		endcase
	endfunction

	// Word ops, result sign extended
	function automatic xlen_t alu32(logic [2:0] op, logic alt, logic [31:0] a,
			logic [31:0] b, logic [4:0] sh);
		logic [31:0] r;
		case (op)
		3'b000:	r = alt ? a - b : a + b;
		3'b001:	r = a << sh;
		default: r = alt ? 32'($signed(a) >>> sh) : a >> sh;
		endcase
		return {{32{r[31]}}, r};
	endfunction

	assign imm_i   = {{52{inst_i.i.imm[11]}}, inst_i.i.imm};
	assign imm_u   = {{32{inst_i.r.funct7[6]}}, inst_i.r.funct7, inst_i.r.rs2,
			inst_i.r.rs1, inst_i.r.funct3, 12'h000};
	assign f3      = inst_i.r.funct3;
	assign f7_zero = inst_i.r.funct7 == 7'b0000000;
	assign f7_alt  = inst_i.r.funct7 == 7'b0100000;
	assign f6_alt  = inst_i.i.imm[11:6] == 6'b010000;

	always_comb begin
		kept = 1'b0;
		res  = '0;
		case (inst_i.r.opcode)
		OP: begin
			kept = f7_zero || (f7_alt && (f3 == 3'b000 || f3 == 3'b101));
			res  = alu64(f3, f7_alt, rs1_data_i, rs2_data_i, rs2_data_i[5:0]);
		end
		OP_IMM: begin
			if (f3 == 3'b001)
				kept = inst_i.i.imm[11:6] == 6'b000000;
			else if (f3 == 3'b101)
				kept = inst_i.i.imm[11:6] == 6'b000000 || f6_alt;
			else
				kept = 1'b1;
			res = alu64(f3, f3 == 3'b101 && f6_alt, rs1_data_i, imm_i, inst_i.i.imm[5:0]);
		end
		OP_32: begin
			kept = (f7_zero && (f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b101)) ||
				(f7_alt && (f3 == 3'b000 || f3 == 3'b101));
			res  = alu32(f3, f7_alt, rs1_data_i[31:0], rs2_data_i[31:0], rs2_data_i[4:0]);
		end
		OP_IMM_32: begin
			kept = f3 == 3'b000 || (f3 == 3'b001 && f7_zero) ||
				(f3 == 3'b101 && (f7_zero || f7_alt));
			// Shift amount sits in the rs2 slot
			res  = alu32(f3, f3 == 3'b101 && f7_alt, rs1_data_i[31:0], imm_i[31:0],
				inst_i.r.rs2);
		end
		LUI: begin
			kept = 1'b1;
			res  = imm_u;
		end
		AUIPC: begin
			kept = 1'b1;
			res  = pc_i + imm_u;
		end
		JAL: begin
			kept = 1'b1;
			res  = pc_i + 64'd4;	// Link
		end
		JALR: begin
			kept = f3 == 3'b000;
			res  = pc_i + 64'd4;
		end
		default: ;
		endcase
	end

	assign wb_o.we   = kept && inst_i.r.rd != '0;
	assign wb_o.rd   = inst_i.r.rd;
	assign wb_o.data = res;

	always_comb begin
		a_no_x0_write: assert (!(wb_o.we && wb_o.rd == '0))
			else $error("write enable raised for x0");
	end

endmodule

`default_nettype wire

/* rtl/rv64_pkg.sv */
`default_nettype none

`include "rv64_config.svh"

package rv64_pkg;

	typedef logic [`XLEN-1:0]		xlen_t;
	typedef logic [$clog2(`NUM_REG)-1:0]	reg_idx_t;

	// Major opcodes handled by the core
	typedef enum logic [6:0] {
		OP		= 7'b01_100_11,
		OP_IMM		= 7'b00_100_11,
		OP_32		= 7'b01_110_11,
		OP_IMM_32	= 7'b00_110_11,
		LUI		= 7'b01_101_11,
		AUIPC		= 7'b00_101_11,
		JAL		= 7'b11_011_11,
		JALR		= 7'b11_001_11,
		BRANCH		= 7'b11_000_11
	} opcode_e;

	// R-type layout
	typedef struct packed {
		logic [6:0]	funct7;
		reg_idx_t	rs2;
		reg_idx_t	rs1;
		logic [2:0]	funct3;
		reg_idx_t	rd;
		opcode_e	opcode;
	} inst_r_t;

	// I-type layout
	typedef struct packed {
		logic [11:0]	imm;
		reg_idx_t	rs1;
		logic [2:0]	funct3;
		reg_idx_t	rd;
		opcode_e	opcode;
	} inst_i_t;

	typedef union packed {
		inst_r_t	r;
		inst_i_t	i;
	} inst_u;

	typedef struct packed {
		logic		we;
		reg_idx_t	rd;
		xlen_t		data;
	} wb_t;

	typedef struct packed {
		logic		valid;
		wb_t		wb;
	} retire_t;

endpackage

`default_nettype wire

/* rtl/rv64_config.svh */
`ifndef RV64_CONFIG_SVH
`define RV64_CONFIG_SVH

// Register and PC width
`define XLEN		64

// Integer register file depth
`define NUM_REG		32

// First fetch address after reset
`define RESET_PC	64'h0000_0000_8000_0000

`endif
